// ==== decode_stage.sv ====
/*
 * Decode slot
 * Holds its instruction through hazard stalls, picks up the hazard
 * index from the outside decoder and builds the immediate prefix
 */

`timescale 1ns/100ps

module decode_stage (
	input  logic                              CLK,
	input  logic                              RSTb,
	input  slurm16_pipeline_pkg::ctrl_state_t state,
	input  logic                              load_pc_request,
	input  slurm16_pipeline_pkg::instr_t      instr_0,
	input  slurm16_pipeline_pkg::word_addr_t  pc_0,
	input  logic                              nop_0,
	input  slurm16_pipeline_pkg::reg_idx_t    hazard_reg0,
	input  logic                              modifies_flags0,
	output slurm16_pipeline_pkg::instr_t      instr_1,
	output slurm16_pipeline_pkg::word_addr_t  pc_1,
	output slurm16_pipeline_pkg::imm_t        imm_1,
	output logic                              nop_1,
	output slurm16_pipeline_pkg::reg_idx_t    hazard_reg1,
	output logic                              modifies_flags1,
	output slurm16_pipeline_pkg::imm_t        imm_reg
);

	logic hold;
	logic is_prefix;

	assign hold = (state == slurm16_pipeline_pkg::st_stall1) ||
		(state == slurm16_pipeline_pkg::st_stall2) ||
		(state == slurm16_pipeline_pkg::st_stall3);

	assign is_prefix = (instr_1[slurm16_pipeline_pkg::BITS - 1 -: 4] ==
		slurm16_pipeline_pkg::IMM_OPCODE);

	// Slot payload, frozen while a hazard stall runs
	always_ff @(posedge CLK) begin
		if (!hold) begin
			instr_1         <= instr_0;
			pc_1            <= pc_0;
			imm_1           <= imm_reg;	// Prefix seen so far
			hazard_reg1     <= hazard_reg0;
			modifies_flags1 <= modifies_flags0;
		end
	end

	// Bubble bit
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			nop_1 <= 1'b1;
		end else begin
			case (state)
				slurm16_pipeline_pkg::st_reset,
				slurm16_pipeline_pkg::st_pre_execute,
				slurm16_pipeline_pkg::st_halt,
				slurm16_pipeline_pkg::st_ins_stall1:	// Fetched word is stale on a miss
					nop_1 <= 1'b1;
				slurm16_pipeline_pkg::st_stall1,
				slurm16_pipeline_pkg::st_stall2,
				slurm16_pipeline_pkg::st_stall3:
					if (load_pc_request)
						nop_1 <= 1'b1;		// Otherwise keep held value
				default:
					nop_1 <= load_pc_request ? 1'b1 : nop_0;
			endcase
		end
	end

	// Immediate prefix register
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			imm_reg <= '0;
		end else if (!nop_1) begin
			if (is_prefix)
				imm_reg <= instr_1[slurm16_pipeline_pkg::IMM_BITS - 1 : 0];
			else if (instr_1 != slurm16_pipeline_pkg::NOP_INSTRUCTION)
				imm_reg <= '0;			// Prefix consumed
		end
	end

endmodule

// ==== execute_retire_stages.sv ====
/*
 * Execute, memory and writeback slots
 * Carry instructions from decode to retirement along with hazard
 * tags, and pick up the condition result leaving execute
 */

`timescale 1ns/100ps

module execute_retire_stages (
	input  logic                              CLK,
	input  slurm16_pipeline_pkg::ctrl_state_t state,
	input  slurm16_pipeline_pkg::instr_t      instr_1,
	input  slurm16_pipeline_pkg::word_addr_t  pc_1,
	input  slurm16_pipeline_pkg::imm_t        imm_1,
	input  logic                              nop_1,
	input  slurm16_pipeline_pkg::reg_idx_t    hazard_reg1,
	input  logic                              modifies_flags1,
	input  logic                              cond_pass_in,
	output slurm16_pipeline_pkg::instr_t      pipeline_stage_2,
	output slurm16_pipeline_pkg::instr_t      pipeline_stage_3,
	output slurm16_pipeline_pkg::instr_t      pipeline_stage_4,
	output logic                              nop_2,
	output logic                              nop_3,
	output logic                              nop_stage_4,
	output slurm16_pipeline_pkg::reg_idx_t    hazard_reg2,
	output slurm16_pipeline_pkg::reg_idx_t    hazard_reg3,
	output logic                              modifies_flags2,
	output logic                              modifies_flags3,
	output slurm16_pipeline_pkg::byte_addr_t  pc_stage_4,
	output logic                              cond_pass_stage4
);

	slurm16_pipeline_pkg::word_addr_t pc_2;
	slurm16_pipeline_pkg::word_addr_t pc_3;
	slurm16_pipeline_pkg::word_addr_t pc_4;
	logic cond_pass_3;				// Condition of the word in the memory slot
	logic warm_up;					// Reset or pre-execute
	logic exec_bubble;

	assign warm_up = (state == slurm16_pipeline_pkg::st_reset) ||
		(state == slurm16_pipeline_pkg::st_pre_execute);

	// Execute also takes bubbles while halted or stalled
	assign exec_bubble = warm_up ||
		(state == slurm16_pipeline_pkg::st_halt) ||
		(state == slurm16_pipeline_pkg::st_stall1) ||
		(state == slurm16_pipeline_pkg::st_stall2) ||
		(state == slurm16_pipeline_pkg::st_stall3);

	always_ff @(posedge CLK) begin
		// Execute slot
		pipeline_stage_2 <= instr_1;
		pc_2             <= pc_1;
		hazard_reg2      <= hazard_reg1;
		modifies_flags2  <= modifies_flags1;
		nop_2            <= exec_bubble ? 1'b1 : nop_1;

		// Memory slot
		pipeline_stage_3 <= pipeline_stage_2;
		pc_3             <= pc_2;
		hazard_reg3      <= hazard_reg2;
		modifies_flags3  <= modifies_flags2;
		cond_pass_3      <= cond_pass_in;	// Condition leaves execute here
		nop_3            <= warm_up ? 1'b1 : nop_2;

		// Writeback slot
		pipeline_stage_4 <= pipeline_stage_3;
		pc_4             <= pc_3;
		cond_pass_stage4 <= cond_pass_3;
		nop_stage_4      <= warm_up ? 1'b1 : nop_3;
	end

	assign pc_stage_4 = {pc_4, 1'b0};		// Back to byte address

endmodule

// ==== fetch_stage.sv ====
/*
 * Fetch slot
 * Captures the word returned by instruction memory with its address
 * and marks it as a bubble unless the pipeline is executing
 */

`timescale 1ns/100ps

module fetch_stage (
	input  logic                              CLK,
	input  slurm16_pipeline_pkg::ctrl_state_t state,
	input  logic                              load_pc_request,
	input  slurm16_pipeline_pkg::instr_t      instruction_in,
	input  slurm16_pipeline_pkg::word_addr_t  instruction_address_in,
	output slurm16_pipeline_pkg::instr_t      instr_0,
	output slurm16_pipeline_pkg::word_addr_t  pc_0,
	output logic                              nop_0
);

	// Payload, taken every cycle
	always_ff @(posedge CLK) begin
		instr_0 <= instruction_in;
		pc_0    <= instruction_address_in;
	end

	// Only st_execute delivers a live word
	always_ff @(posedge CLK) begin
		if (state != slurm16_pipeline_pkg::st_execute)
			nop_0 <= 1'b1;
		else
			nop_0 <= load_pc_request;	// Redirect kills the word behind the branch
	end

endmodule

// ==== pipeline_control.sv ====
/*
 * Pipeline controller
 * State machine that sequences fetch, stalls on hazards and misses,
 * follows branch redirects and parks the CPU in halt until woken
 */

`timescale 1ns/100ps

module pipeline_control (
	input  logic                              CLK,
	input  logic                              RSTb,
	input  logic                              instruction_valid,
	input  logic                              hazard_1,
	input  logic                              hazard_2,
	input  logic                              hazard_3,
	input  logic                              load_pc_request,
	input  logic                              halt_request,
	input  logic                              wake_request,
	input  logic                              nop_0,
	input  logic                              nop_1,
	input  logic                              nop_2,
	input  logic                              nop_3,
	input  slurm16_pipeline_pkg::byte_addr_t  load_pc_address,
	output slurm16_pipeline_pkg::ctrl_state_t state,
	output logic                              instruction_request,
	output slurm16_pipeline_pkg::word_addr_t  instruction_address
);

	slurm16_pipeline_pkg::word_addr_t pc;
	slurm16_pipeline_pkg::word_addr_t prev_pc;	// Rewind point for stalls and misses
	slurm16_pipeline_pkg::word_addr_t branch_target;
	logic halt_latched;
	logic stall_1;
	logic stall_2;
	logic stall_3;

	assign branch_target = load_pc_address[slurm16_pipeline_pkg::ADDRESS_BITS - 1 : 1];

	// Hazards only count between two live instructions, and never under a branch
	assign stall_1 = hazard_1 && !load_pc_request && !nop_0 && !nop_1;
	assign stall_2 = hazard_2 && !load_pc_request && !nop_0 && !nop_2;
	assign stall_3 = hazard_3 && !load_pc_request && !nop_0 && !nop_3;

	// Memory is left free while halted
	assign instruction_request = (state != slurm16_pipeline_pkg::st_halt);
	assign instruction_address = pc;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= slurm16_pipeline_pkg::st_reset;
		end else begin
			case (state)
				slurm16_pipeline_pkg::st_reset:
					state <= slurm16_pipeline_pkg::st_pre_execute;
				slurm16_pipeline_pkg::st_pre_execute:
					state <= slurm16_pipeline_pkg::st_execute;
				slurm16_pipeline_pkg::st_halt:
					if (wake_request)
						state <= slurm16_pipeline_pkg::st_execute;
				slurm16_pipeline_pkg::st_execute: begin
					if (!instruction_valid)		// Miss wins over everything
						state <= slurm16_pipeline_pkg::st_ins_stall1;
					else if (stall_1)
						state <= slurm16_pipeline_pkg::st_stall1;
					else if (stall_2)
						state <= slurm16_pipeline_pkg::st_stall2;
					else if (stall_3)
						state <= slurm16_pipeline_pkg::st_stall3;
					else if (halt_latched)
						state <= slurm16_pipeline_pkg::st_halt;
				end
				slurm16_pipeline_pkg::st_stall1:
					state <= slurm16_pipeline_pkg::st_stall2;
				slurm16_pipeline_pkg::st_stall2:
					if (load_pc_request)		// Branch cuts the stall short
						state <= slurm16_pipeline_pkg::st_execute;
					else
						state <= slurm16_pipeline_pkg::st_stall3;
				slurm16_pipeline_pkg::st_stall3:
					state <= slurm16_pipeline_pkg::st_execute;
				slurm16_pipeline_pkg::st_ins_stall1:
					state <= slurm16_pipeline_pkg::st_ins_stall2;
				slurm16_pipeline_pkg::st_ins_stall2:
					if (instruction_valid)		// Miss resolved
						state <= slurm16_pipeline_pkg::st_execute;
				default:
					state <= slurm16_pipeline_pkg::st_reset;
			endcase
		end
	end

	// Program counter and rewind copy
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			pc      <= '0;
			prev_pc <= '0;
		end else begin
			case (state)
				slurm16_pipeline_pkg::st_reset: begin
					pc      <= '0;
					prev_pc <= '0;
				end
				slurm16_pipeline_pkg::st_pre_execute,
				slurm16_pipeline_pkg::st_execute: begin
					prev_pc <= pc;
					pc      <= load_pc_request ? branch_target : pc + 1'b1;
				end
				slurm16_pipeline_pkg::st_stall1,
				slurm16_pipeline_pkg::st_stall2,
				slurm16_pipeline_pkg::st_stall3,
				slurm16_pipeline_pkg::st_ins_stall1:
					pc <= load_pc_request ? branch_target : prev_pc;	// Refetch stalled word
				default:				// Halt and miss wait keep PC unless redirected
					if (load_pc_request)
						pc <= branch_target;
			endcase
		end
	end

	// Halt request is a pulse, hold it until halt is entered
	always_ff @(posedge CLK) begin
		if (!RSTb)
			halt_latched <= 1'b0;
		else if (state == slurm16_pipeline_pkg::st_halt)
			halt_latched <= 1'b0;
		else if (halt_request)
			halt_latched <= 1'b1;
	end

endmodule

// ==== run.sh ====
#!/bin/sh
# Compile and run the pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/100ps \
	--top-module tb_slurm16_pipeline -f sim.f

status=0
out=$(./obj_dir/Vtb_slurm16_pipeline) || status=$?
echo "$out"

if echo "$out" | grep -q "All tests passed"; then
	exit 0
fi
echo "Simulation failed (exit status $status)"
exit 1

// ==== sim.f ====
slurm16_pipeline_pkg.sv
pipeline_control.sv
fetch_stage.sv
decode_stage.sv
execute_retire_stages.sv
slurm16_pipeline.sv
tb_slurm16_pipeline.sv

// ==== slurm16_pipeline.sv ====
/*
 * SLURM16 instruction-flow pipeline
 * Connects the controller and the five slots to instruction memory
 * and to the decode, execute and writeback logic of the CPU
 */

`timescale 1ns/100ps

module slurm16_pipeline (
	input  logic                             CLK,
	input  logic                             RSTb,
	// Instruction memory
	output logic                             instruction_request,
	input  logic                             instruction_valid,		// Low on a miss
	output slurm16_pipeline_pkg::word_addr_t instruction_address,
	input  slurm16_pipeline_pkg::instr_t     instruction_in,
	input  slurm16_pipeline_pkg::word_addr_t instruction_address_in,
	// Slot contents to the datapath
	output slurm16_pipeline_pkg::instr_t     pipeline_stage_0,
	output slurm16_pipeline_pkg::instr_t     pipeline_stage_1,
	output slurm16_pipeline_pkg::instr_t     pipeline_stage_2,
	output slurm16_pipeline_pkg::instr_t     pipeline_stage_3,
	output slurm16_pipeline_pkg::instr_t     pipeline_stage_4,
	output slurm16_pipeline_pkg::byte_addr_t pc_stage_4,
	output logic                             nop_stage_2,		// Execute must not change state
	output logic                             nop_stage_4,		// No writeback
	output slurm16_pipeline_pkg::imm_t       imm_reg,
	// Hazards
	input  logic                             hazard_1,
	input  logic                             hazard_2,
	input  logic                             hazard_3,
	input  slurm16_pipeline_pkg::reg_idx_t   hazard_reg0,
	input  logic                             modifies_flags0,
	output slurm16_pipeline_pkg::reg_idx_t   hazard_reg1,
	output slurm16_pipeline_pkg::reg_idx_t   hazard_reg2,
	output slurm16_pipeline_pkg::reg_idx_t   hazard_reg3,
	output logic                             modifies_flags1,
	output logic                             modifies_flags2,
	output logic                             modifies_flags3,
	// Control
	input  logic                             halt_request,
	input  logic                             wake_request,
	input  logic                             load_pc_request,		// Branch from execute
	input  slurm16_pipeline_pkg::byte_addr_t load_pc_address,
	input  logic                             cond_pass_in,
	output logic                             cond_pass_stage4
);

	slurm16_pipeline_pkg::ctrl_state_t state;
	slurm16_pipeline_pkg::word_addr_t  pc_0;
	slurm16_pipeline_pkg::word_addr_t  pc_1;
	slurm16_pipeline_pkg::imm_t        imm_1;
	logic nop_0;
	logic nop_1;
	logic nop_3;

	pipeline_control i_pipeline_control (
		.CLK                 (CLK),
		.RSTb                (RSTb),
		.instruction_valid   (instruction_valid),
		.hazard_1            (hazard_1),
		.hazard_2            (hazard_2),
		.hazard_3            (hazard_3),
		.load_pc_request     (load_pc_request),
		.halt_request        (halt_request),
		.wake_request        (wake_request),
		.nop_0               (nop_0),
		.nop_1               (nop_1),
		.nop_2               (nop_stage_2),
		.nop_3               (nop_3),
		.load_pc_address     (load_pc_address),
		.state               (state),
		.instruction_request (instruction_request),
		.instruction_address (instruction_address)
	);

	fetch_stage i_fetch_stage (
		.CLK                    (CLK),
		.state                  (state),
		.load_pc_request        (load_pc_request),
		.instruction_in         (instruction_in),
		.instruction_address_in (instruction_address_in),
		.instr_0                (pipeline_stage_0),
		.pc_0                   (pc_0),
		.nop_0                  (nop_0)
	);

	decode_stage i_decode_stage (
		.CLK             (CLK),
		.RSTb            (RSTb),
		.state           (state),
		.load_pc_request (load_pc_request),
		.instr_0         (pipeline_stage_0),
		.pc_0            (pc_0),
		.nop_0           (nop_0),
		.hazard_reg0     (hazard_reg0),
		.modifies_flags0 (modifies_flags0),
		.instr_1         (pipeline_stage_1),
		.pc_1            (pc_1),
		.imm_1           (imm_1),
		.nop_1           (nop_1),
		.hazard_reg1     (hazard_reg1),
		.modifies_flags1 (modifies_flags1),
		.imm_reg         (imm_reg)
	);

	execute_retire_stages i_execute_retire_stages (
		.CLK              (CLK),
		.state            (state),
		.instr_1          (pipeline_stage_1),
		.pc_1             (pc_1),
		.imm_1            (imm_1),
		.nop_1            (nop_1),
		.hazard_reg1      (hazard_reg1),
		.modifies_flags1  (modifies_flags1),
		.cond_pass_in     (cond_pass_in),
		.pipeline_stage_2 (pipeline_stage_2),
		.pipeline_stage_3 (pipeline_stage_3),
		.pipeline_stage_4 (pipeline_stage_4),
		.nop_2            (nop_stage_2),
		.nop_3            (nop_3),
		.nop_stage_4      (nop_stage_4),
		.hazard_reg2      (hazard_reg2),
		.hazard_reg3      (hazard_reg3),
		.modifies_flags2  (modifies_flags2),
		.modifies_flags3  (modifies_flags3),
		.pc_stage_4       (pc_stage_4),
		.cond_pass_stage4 (cond_pass_stage4)
	);

endmodule

// ==== slurm16_pipeline_pkg.sv ====
/*
 * SLURM16 pipeline package
 * Widths, vector types, instruction constants and controller states
 * shared by the instruction-flow controller and the pipeline slots
 */

package slurm16_pipeline_pkg;

	localparam int BITS          = 16;		// Instruction and data width
	localparam int ADDRESS_BITS  = 16;		// Byte address width
	localparam int REGISTER_BITS = 4;		// Register index width
	localparam int IMM_BITS      = BITS * 3 / 4;	// Immediate prefix payload

	typedef logic [BITS - 1 : 0]          instr_t;
	typedef logic [ADDRESS_BITS - 1 : 0]  byte_addr_t;
	typedef logic [ADDRESS_BITS - 2 : 0]  word_addr_t;	// Byte address without bit 0
	typedef logic [IMM_BITS - 1 : 0]      imm_t;
	typedef logic [REGISTER_BITS - 1 : 0] reg_idx_t;

	// Top nibble of an imm prefix word
	localparam logic [3:0] IMM_OPCODE = 4'h1;

	// All-zero word, leaves imm prefix untouched
	localparam instr_t NOP_INSTRUCTION = '0;

	// Controller states
	typedef enum logic [3:0] {
		st_reset,
		st_pre_execute,
		st_execute,
		st_halt,
		st_stall1,		// Hazard with slot 1, three cycles
		st_stall2,		// Hazard with slot 2, two cycles
		st_stall3,		// Hazard with slot 3, one cycle
		st_ins_stall1,		// Miss, PC rewind
		st_ins_stall2		// Miss, wait for valid
	} ctrl_state_t;

endpackage

// ==== tb_slurm16_pipeline.sv ====
/*
 * Testbench for the SLURM16 instruction-flow pipeline
 * Runs sequential fetch, slot timing, branch, immediate prefix,
 * hazard and miss stalls and halt against a one-cycle memory model
 */

`timescale 1ns/100ps

module tb_slurm16_pipeline;

	logic                             CLK;
	logic                             RSTb;
	logic                             instruction_request;
	logic                             instruction_valid;
	slurm16_pipeline_pkg::word_addr_t instruction_address;
	slurm16_pipeline_pkg::instr_t     instruction_in = '0;
	slurm16_pipeline_pkg::word_addr_t instruction_address_in = '0;
	slurm16_pipeline_pkg::instr_t     pipeline_stage_0;
	slurm16_pipeline_pkg::instr_t     pipeline_stage_1;
	slurm16_pipeline_pkg::instr_t     pipeline_stage_2;
	slurm16_pipeline_pkg::instr_t     pipeline_stage_3;
	slurm16_pipeline_pkg::instr_t     pipeline_stage_4;
	slurm16_pipeline_pkg::byte_addr_t pc_stage_4;
	logic                             nop_stage_2;
	logic                             nop_stage_4;
	slurm16_pipeline_pkg::imm_t       imm_reg;
	logic                             hazard_1;
	logic                             hazard_2;
	logic                             hazard_3;
	slurm16_pipeline_pkg::reg_idx_t   hazard_reg0 = '0;
	logic                             modifies_flags0 = 1'b0;
	slurm16_pipeline_pkg::reg_idx_t   hazard_reg1;
	slurm16_pipeline_pkg::reg_idx_t   hazard_reg2;
	slurm16_pipeline_pkg::reg_idx_t   hazard_reg3;
	logic                             modifies_flags1;
	logic                             modifies_flags2;
	logic                             modifies_flags3;
	logic                             halt_request;
	logic                             wake_request;
	logic                             load_pc_request;
	slurm16_pipeline_pkg::byte_addr_t load_pc_address;
	logic                             cond_pass_in;
	logic                             cond_pass_stage4;

	slurm16_pipeline_pkg::word_addr_t addr_q1;	// Request address one cycle back
	slurm16_pipeline_pkg::word_addr_t addr_q2;	// Two cycles back, lines up with fetch slot
	logic                             check_on;
	logic [15:0]                      lfsr_state;

	slurm16_pipeline i_slurm16_pipeline (.*);

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;			// 20 ns period
	end

	// Memory contents: address with top nibble 2, prefix words at xx2a
	function automatic slurm16_pipeline_pkg::instr_t mem_word(
		input slurm16_pipeline_pkg::word_addr_t addr);
		if (addr[5:0] == 6'h2a)
			return {slurm16_pipeline_pkg::IMM_OPCODE, addr[11:0]};
		return {4'h2, addr[11:0]};
	endfunction

	// Fibonacci LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic draw_bits(input int count, output int value);
		value = 0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_next(lfsr_state);	// One step per bit
			value = (value << 1) | lfsr_state[0];
		end
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("ERR %0t %s: got %0h, expected %0h", $time, what, got, expected);
			$display("Some tests failed");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		$display("Some tests failed");
		$fatal(1, "Wait limit exceeded");
	endtask

	// Redirect pulse, PC must follow on the next cycle
	task automatic pulse_branch(input slurm16_pipeline_pkg::byte_addr_t target);
		@(posedge CLK);
		load_pc_request <= 1'b1;
		load_pc_address <= target;
		@(posedge CLK);
		load_pc_request <= 1'b0;
		@(negedge CLK);
		check_value("branch address", instruction_address, target[15:1]);
	endtask

	// One-cycle instruction memory, answers every cycle
	always @(posedge CLK) begin
		instruction_in         <= mem_word(instruction_address);
		instruction_address_in <= instruction_address;	// Echo
		addr_q1                <= instruction_address;
		addr_q2                <= addr_q1;
	end

	// Outside decoder, tags line up with the word entering the fetch slot
	always @(posedge CLK) begin
		hazard_reg0     <= instruction_in[3:0];
		modifies_flags0 <= instruction_in[4];
	end

	// Fetch slot and retired words must match the memory image
	always @(negedge CLK) begin
		if (check_on) begin
			check_value("fetch slot word", pipeline_stage_0, mem_word(addr_q2));
			if (!nop_stage_4)
				check_value("writeback word", pipeline_stage_4, mem_word(pc_stage_4[15:1]));
		end
	end

	initial begin
		int waited;
		int delay;
		int miss_len;
		slurm16_pipeline_pkg::word_addr_t prev_addr;
		slurm16_pipeline_pkg::instr_t held_word;
		slurm16_pipeline_pkg::instr_t tracked_word;

		RSTb              = 1'b0;
		instruction_valid = 1'b1;
		hazard_1          = 1'b0;
		hazard_2          = 1'b0;
		hazard_3          = 1'b0;
		halt_request      = 1'b0;
		wake_request      = 1'b0;
		load_pc_request   = 1'b0;
		load_pc_address   = '0;
		cond_pass_in      = 1'b0;
		check_on          = 1'b0;
		lfsr_state        = 16'd32;			// Seed
		repeat (5) @(posedge CLK);
		RSTb <= 1'b1;

		// Sequential fetch after reset
		waited = 0;
		while (instruction_address !== 15'd3) begin
			@(negedge CLK);
			waited++;
			if (waited > 20)
				report_timeout("fetch to start after reset");
		end
		@(posedge CLK);
		check_on <= 1'b1;
		@(negedge CLK);
		prev_addr = instruction_address;
		repeat (8) begin
			@(negedge CLK);
			check_value("request after reset", instruction_request, 1'b1);
			check_value("sequential address", instruction_address, prev_addr + 1'b1);
			prev_addr = instruction_address;
		end

		// Fetch slot word walks one slot per cycle to writeback
		prev_addr = addr_q2;
		tracked_word = mem_word(prev_addr);
		@(posedge CLK);
		@(negedge CLK);
		check_value("decode word", pipeline_stage_1, tracked_word);
		check_value("decode hazard tag", hazard_reg1, tracked_word[3:0]);
		check_value("decode flag tag", modifies_flags1, tracked_word[4]);
		@(posedge CLK);
		cond_pass_in <= 1'b1;			// Condition holds while it executes
		@(negedge CLK);
		check_value("execute word", pipeline_stage_2, tracked_word);
		check_value("execute hazard tag", hazard_reg2, tracked_word[3:0]);
		check_value("execute flag tag", modifies_flags2, tracked_word[4]);
		@(posedge CLK);
		cond_pass_in <= 1'b0;
		@(negedge CLK);
		check_value("memory word", pipeline_stage_3, tracked_word);
		check_value("memory hazard tag", hazard_reg3, tracked_word[3:0]);
		check_value("memory flag tag", modifies_flags3, tracked_word[4]);
		check_value("condition before writeback", cond_pass_stage4, 1'b0);
		@(negedge CLK);
		check_value("slot timing word", pipeline_stage_4, tracked_word);
		check_value("slot timing bubble", nop_stage_4, 1'b0);
		check_value("slot timing pc", pc_stage_4, {prev_addr, 1'b0});
		check_value("condition at writeback", cond_pass_stage4, 1'b1);

		// Branch kills the fetch and decode slots behind it
		pulse_branch(16'h0600);
		repeat (3) @(negedge CLK);
		check_value("first shadow bubble", nop_stage_4, 1'b1);
		@(negedge CLK);
		check_value("second shadow bubble", nop_stage_4, 1'b1);

		// Immediate prefix at word 1aa, cleared by the next word
		pulse_branch(16'h0354);
		waited = 0;
		while (pipeline_stage_1 !== mem_word(15'h1aa)) begin
			@(negedge CLK);
			waited++;
			if (waited > 10)
				report_timeout("prefix word in decode");
		end
		@(negedge CLK);
		check_value("prefix load", imm_reg, 12'h1aa);
		@(negedge CLK);
		check_value("prefix clear", imm_reg, 12'h000);

		repeat (2) begin
			// Hazard with slot 1, three-cycle stall
			draw_bits(3, delay);
			repeat (delay + 2) @(posedge CLK);
			hazard_1 <= 1'b1;
			@(posedge CLK);
			hazard_1 <= 1'b0;
			@(negedge CLK);
			held_word = pipeline_stage_1;
			repeat (3) begin
				@(negedge CLK);
				check_value("decode hold", pipeline_stage_1, held_word);
				check_value("execute bubble", nop_stage_2, 1'b1);
			end

			// Miss of random length, PC rewinds and waits for valid
			draw_bits(3, delay);
			draw_bits(2, miss_len);
			repeat (delay + 1) @(posedge CLK);
			instruction_valid <= 1'b0;
			@(negedge CLK);
			prev_addr = instruction_address;	// Rewind point
			repeat (miss_len + 1) @(posedge CLK);
			instruction_valid <= 1'b1;
			repeat (2) @(negedge CLK);
			check_value("rewound address", instruction_address, prev_addr);
			waited = 0;
			while (instruction_address === prev_addr) begin
				@(negedge CLK);
				waited++;
				if (waited > 10)
					report_timeout("fetch to resume after miss");
			end
			check_value("resumed address", instruction_address, prev_addr + 1'b1);
		end

		// Halt drops requests until woken
		@(posedge CLK);
		halt_request <= 1'b1;
		@(posedge CLK);
		halt_request <= 1'b0;
		waited = 0;
		while (instruction_request !== 1'b0) begin
			@(negedge CLK);
			waited++;
			if (waited > 20)
				report_timeout("halt to drop the request");
		end
		repeat (3) begin
			@(negedge CLK);
			check_value("request while halted", instruction_request, 1'b0);
		end
		@(posedge CLK);
		wake_request <= 1'b1;
		@(posedge CLK);
		wake_request <= 1'b0;
		waited = 0;
		while (instruction_request !== 1'b1) begin
			@(negedge CLK);
			waited++;
			if (waited > 10)
				report_timeout("wake to restore the request");
		end
		repeat (8) @(negedge CLK);			// Refill runs under the checker

		$display("All tests passed");
		$finish;
	end

endmodule
